// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = traceFunnelTb
FILELIST  = verilog.f
OBJDIR    = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: logic/sourceEnableMap.sv
// Trace source enable map
// Fuse map and virtual disable mask give the enabled physical cores

`timescale 1ns/1ps
`default_nettype none

`include "traceFunnel_consts.svh"

module sourceEnableMap (
  input  logic                        clk,
  input  logic                        reset_i,
  input  traceFunnelPkg::funnelCfg_t  cfg_i,
  output logic [`TF_NUM_CORES-1:0]    enabledSrcs_o,
  output logic [`TF_COUNT_WIDTH-1:0]  numEnabled_o
);

  import traceFunnelPkg::*;

  logic [`TF_NUM_CORES-1:0]   enNext;
  logic [`TF_COUNT_WIDTH-1:0] cntNext;

  // --------------------------------------------------
  // Virtual to physical mapping
  // --------------------------------------------------
  always_comb begin
    fuseEntry_t entry;
    enNext  = '0;
    cntNext = '0;
    for (int p = 0; p < `TF_NUM_CORES; p++) begin
      entry = cfg_i.fuse.core[p];
      // Disable bit is indexed by the core's virtual ID
      enNext[p] = cfg_i.active & entry.fuseEn & ~cfg_i.disableMask[entry.vid];
      cntNext   = cntNext + `TF_COUNT_WIDTH'(enNext[p]);
    end
  end

  // One cycle behind the configuration
  always_ff @(posedge clk) begin
    if (reset_i) begin
      enabledSrcs_o <= '0;
      numEnabled_o  <= '0;
    end else begin
      enabledSrcs_o <= enNext;
      numEnabled_o  <= cntNext;
    end
  end

endmodule

`default_nettype wire

// File: logic/traceFunnel.sv
// Trace funnel top
// Branch beats into a local trace RAM, configured and read over APB

`timescale 1ns/1ps
`default_nettype none

`include "traceFunnel_consts.svh"

module traceFunnel (
  input  logic                          clk,
  input  logic                          reset_i,
  // APB slave
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [`TF_APB_ADDR_WIDTH-1:0] paddr_i,
  input  logic [31:0]                   pwdata_i,
  output logic [31:0]                   prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  // Even branch
  input  logic [`TF_BRANCH_CORES-1:0]   evenVld_i,
  input  logic                          evenSrc_i,
  input  logic [`TF_DATA_WIDTH-1:0]     evenData_i,
  // Odd branch
  input  logic [`TF_BRANCH_CORES-1:0]   oddVld_i,
  input  logic                          oddSrc_i,
  input  logic [`TF_DATA_WIDTH-1:0]     oddData_i,
  // Toward the branches
  output logic                          traceBp_o,
  output logic [`TF_NUM_CORES-1:0]      enabledSrcs_o,
  output logic                          funnelActive_o
);

  import traceFunnelPkg::*;

  funnelCfg_t                    cfg;
  sinkStatus_t                   sinkStatus;
  traceBeat_t                    evenBeat;
  traceBeat_t                    oddBeat;
  logic [`TF_COUNT_WIDTH-1:0]    numEnabled;
  logic                          wpClear;
  logic                          ramWrEn;
  logic [`TF_RAM_ADDR_WIDTH-1:0] ramWrAddr;
  logic [`TF_DATA_WIDTH-1:0]     ramWrData;
  logic                          ramRdEn;
  logic [`TF_RAM_ADDR_WIDTH-1:0] ramRdAddr;
  logic [`TF_DATA_WIDTH-1:0]     ramRdData;

  // A branch carries a beat when any of its cores is valid
  assign evenBeat = '{vld: |evenVld_i, src: evenSrc_i, data: evenData_i};
  assign oddBeat  = '{vld: |oddVld_i, src: oddSrc_i, data: oddData_i};

  // --------------------------------------------------
  // Registers and source map
  // --------------------------------------------------
  traceFunnelRegs regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .numEnabled_i   (numEnabled),
    .sinkStatus_i   (sinkStatus),
    .ramRdData_i    (ramRdData),
    .cfg_o          (cfg),
    .wpClear_o      (wpClear),
    .ramRdEn_o      (ramRdEn),
    .ramRdAddr_o    (ramRdAddr),
    .funnelActive_o (funnelActive_o)
  );

  sourceEnableMap srcMap (
    .clk           (clk),
    .reset_i       (reset_i),
    .cfg_i         (cfg),
    .enabledSrcs_o (enabledSrcs_o),
    .numEnabled_o  (numEnabled)
  );

  // --------------------------------------------------
  // Sink and RAM
  // --------------------------------------------------
  traceSink sink (
    .clk         (clk),
    .reset_i     (reset_i),
    .cfg_i       (cfg),
    .evenBeat_i  (evenBeat),
    .oddBeat_i   (oddBeat),
    .wpClear_i   (wpClear),
    .ramWrEn_o   (ramWrEn),
    .ramWrAddr_o (ramWrAddr),
    .ramWrData_o (ramWrData),
    .status_o    (sinkStatus),
    .traceBp_o   (traceBp_o)
  );

  traceRam ram (
    .clk      (clk),
    .wrEn_i   (ramWrEn),
    .wrAddr_i (ramWrAddr),
    .wrData_i (ramWrData),
    .rdEn_i   (ramRdEn),
    .rdAddr_i (ramRdAddr),
    .rdData_o (ramRdData)
  );

endmodule

`default_nettype wire

// File: logic/traceFunnelPkg.sv
// Trace funnel types
// Beats from the trace-hop branches, fuse map, configuration and sink status

`default_nettype none

`include "traceFunnel_consts.svh"

package traceFunnelPkg;

  // One beat from an even or odd branch
  typedef struct packed {
    logic                      vld;
    logic                      src;
    logic [`TF_DATA_WIDTH-1:0] data;
  } traceBeat_t;

  // Fuse entry of one physical core, enable sits above the virtual ID
  typedef struct packed {
    logic                         fuseEn;
    logic [`TF_CORE_ID_WIDTH-1:0] vid;
  } fuseEntry_t;

  typedef struct packed {
    fuseEntry_t [`TF_NUM_CORES-1:0] core;
  } fuseMap_t;

  // Programmed configuration
  typedef struct packed {
    logic                     active;
    logic [`TF_NUM_CORES-1:0] disableMask;
    fuseMap_t                 fuse;
    logic                     ramEn;
    logic                     wrapMode;
  } funnelCfg_t;

  // Write side state of the trace RAM
  typedef struct packed {
    logic [`TF_RAM_ADDR_WIDTH-1:0] wrPtr;
    logic                          wrapped;
    logic                          full;
  } sinkStatus_t;

endpackage

`default_nettype wire

// File: logic/traceFunnelRegs.sv
// Trace funnel register block
// APB slave for configuration, pointers, status and trace RAM readout

`timescale 1ns/1ps
`default_nettype none

`include "traceFunnel_consts.svh"

module traceFunnelRegs (
  input  logic                            clk,
  input  logic                            reset_i,
  // APB slave
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [`TF_APB_ADDR_WIDTH-1:0]   paddr_i,
  input  logic [31:0]                     pwdata_i,
  output logic [31:0]                     prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  // Status from the datapath
  input  logic [`TF_COUNT_WIDTH-1:0]      numEnabled_i,
  input  traceFunnelPkg::sinkStatus_t     sinkStatus_i,
  input  logic [`TF_DATA_WIDTH-1:0]       ramRdData_i,
  // Configuration and control
  output traceFunnelPkg::funnelCfg_t      cfg_o,
  output logic                            wpClear_o,
  output logic                            ramRdEn_o,
  output logic [`TF_RAM_ADDR_WIDTH-1:0]   ramRdAddr_o,
  output logic                            funnelActive_o
);

  import traceFunnelPkg::*;

  funnelCfg_t                    cfgQ;
  logic [`TF_RAM_ADDR_WIDTH-1:0] rdPtrQ;
  logic                          dataWaitQ;
  logic                          access;
  logic                          dataRead;
  logic                          wrEn;

  // --------------------------------------------------
  // APB handshake
  // --------------------------------------------------
  assign access   = psel_i & penable_i;
  assign dataRead = access & ~pwrite_i & (paddr_i == `TF_REG_DATA);
  // All writes finish in their first access cycle
  assign wrEn     = access & pwrite_i;

  // RAM data read issues in the first access cycle, data comes back in the second
  assign ramRdEn_o   = dataRead & ~dataWaitQ;
  assign ramRdAddr_o = rdPtrQ;
  assign pready_o    = access & (~dataRead | dataWaitQ);
  assign pslverr_o   = 1'b0;

  // Sink clears its pointer and flags on the edge ending this access
  assign wpClear_o = wrEn & (paddr_i == `TF_REG_WP);

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      cfgQ      <= '0;
      rdPtrQ    <= '0;
      dataWaitQ <= 1'b0;
    end else begin
      dataWaitQ <= ramRdEn_o;
      // Pointer wraps with the RAM depth
      if (dataRead && dataWaitQ) begin
        rdPtrQ <= rdPtrQ + 1'b1;
      end
      if (wrEn) begin
        case (paddr_i)
          `TF_REG_CONTROL: cfgQ.active      <= pwdata_i[0];
          `TF_REG_DISABLE: cfgQ.disableMask <= pwdata_i[`TF_NUM_CORES-1:0];
          `TF_REG_FUSE:    cfgQ.fuse        <= fuseMap_t'(pwdata_i);
          `TF_REG_RAMCTRL: begin
            cfgQ.ramEn    <= pwdata_i[0];
            cfgQ.wrapMode <= pwdata_i[1];
          end
          `TF_REG_RP:      rdPtrQ <= pwdata_i[`TF_RAM_ADDR_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  assign cfg_o          = cfgQ;
  assign funnelActive_o = cfgQ.active;

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      `TF_REG_CONTROL: prdata_o[0] = cfgQ.active;
      `TF_REG_DISABLE: prdata_o[`TF_NUM_CORES-1:0] = cfgQ.disableMask;
      `TF_REG_FUSE:    prdata_o = cfgQ.fuse;
      `TF_REG_RAMCTRL: prdata_o[1:0] = {cfgQ.wrapMode, cfgQ.ramEn};
      `TF_REG_WP: begin
        prdata_o[`TF_RAM_ADDR_WIDTH-1:0] = sinkStatus_i.wrPtr;
        // Full next to the wrapped flag
        prdata_o[30] = sinkStatus_i.full;
        prdata_o[31] = sinkStatus_i.wrapped;
      end
      `TF_REG_RP:      prdata_o[`TF_RAM_ADDR_WIDTH-1:0] = rdPtrQ;
      `TF_REG_DATA:    prdata_o = ramRdData_i;
      `TF_REG_STATUS:  prdata_o[`TF_COUNT_WIDTH-1:0] = numEnabled_i;
      default:         prdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/traceFunnel_consts.svh
// Trace funnel constants
// Core counts, widths, trace RAM depth and the register map offsets

`ifndef TRACE_FUNNEL_CONSTS_SVH
`define TRACE_FUNNEL_CONSTS_SVH

// Cores and trace beats
`define TF_NUM_CORES        8
`define TF_BRANCH_CORES     4
`define TF_CORE_ID_WIDTH    3
`define TF_COUNT_WIDTH      4
`define TF_DATA_WIDTH       32

// Local trace RAM
`define TF_RAM_DEPTH        16
`define TF_RAM_ADDR_WIDTH   4

// APB register map, one word per register
`define TF_APB_ADDR_WIDTH   8
`define TF_REG_CONTROL      8'h00
`define TF_REG_DISABLE      8'h04
`define TF_REG_FUSE         8'h08
`define TF_REG_RAMCTRL      8'h0C
`define TF_REG_WP           8'h10
`define TF_REG_RP           8'h14
`define TF_REG_DATA         8'h18
`define TF_REG_STATUS       8'h1C

`endif

// File: logic/traceRam.sv
// Trace RAM
// One write port and one registered read port

`timescale 1ns/1ps
`default_nettype none

`include "traceFunnel_consts.svh"

module traceRam (
  input  logic                          clk,
  input  logic                          wrEn_i,
  input  logic [`TF_RAM_ADDR_WIDTH-1:0] wrAddr_i,
  input  logic [`TF_DATA_WIDTH-1:0]     wrData_i,
  input  logic                          rdEn_i,
  input  logic [`TF_RAM_ADDR_WIDTH-1:0] rdAddr_i,
  output logic [`TF_DATA_WIDTH-1:0]     rdData_o
);

  logic [`TF_DATA_WIDTH-1:0] mem [`TF_RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      mem[wrAddr_i] <= wrData_i;
    end
    // Read data valid the cycle after rdEn_i
    if (rdEn_i) begin
      rdData_o <= mem[rdAddr_i];
    end
  end

endmodule

`default_nettype wire

// File: logic/traceSink.sv
// Trace sink
// Merges even and odd branch beats into the trace RAM in arrival order

`timescale 1ns/1ps
`default_nettype none

`include "traceFunnel_consts.svh"

module traceSink (
  input  logic                            clk,
  input  logic                            reset_i,
  input  traceFunnelPkg::funnelCfg_t      cfg_i,
  input  traceFunnelPkg::traceBeat_t      evenBeat_i,
  input  traceFunnelPkg::traceBeat_t      oddBeat_i,
  input  logic                            wpClear_i,
  // RAM write port
  output logic                            ramWrEn_o,
  output logic [`TF_RAM_ADDR_WIDTH-1:0]   ramWrAddr_o,
  output logic [`TF_DATA_WIDTH-1:0]       ramWrData_o,
  output traceFunnelPkg::sinkStatus_t     status_o,
  output logic                            traceBp_o
);

  import traceFunnelPkg::*;

  localparam logic [`TF_RAM_ADDR_WIDTH-1:0] LastAddr =
    `TF_RAM_ADDR_WIDTH'(`TF_RAM_DEPTH - 1);

  traceBeat_t                    holdQ;
  logic [`TF_RAM_ADDR_WIDTH-1:0] wrPtrQ;
  logic                          wrappedQ;
  logic                          fullQ;
  logic                          accept;
  logic                          wrEn;
  logic                          capture;
  logic [`TF_DATA_WIDTH-1:0]     wrData;

  // Beats only land while the funnel and the RAM are both on
  assign accept = cfg_i.active & cfg_i.ramEn & ~fullQ;

  // --------------------------------------------------
  // Branch merge
  // --------------------------------------------------
  always_comb begin
    wrEn    = 1'b0;
    capture = 1'b0;
    wrData  = evenBeat_i.data;
    if (holdQ.vld) begin
      // Held odd beat goes first, new beats are ignored under back-pressure
      wrEn   = accept;
      wrData = holdQ.data;
    end else if (evenBeat_i.vld) begin
      wrEn    = accept;
      capture = accept & oddBeat_i.vld;
    end else if (oddBeat_i.vld) begin
      wrEn   = accept;
      wrData = oddBeat_i.data;
    end
  end

  // --------------------------------------------------
  // Holding register and write pointer
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      holdQ    <= '0;
      wrPtrQ   <= '0;
      wrappedQ <= 1'b0;
      fullQ    <= 1'b0;
    end else begin
      if (capture) begin
        holdQ <= oddBeat_i;
      end else begin
        holdQ.vld <= 1'b0;
      end
      if (wpClear_i) begin
        wrPtrQ   <= '0;
        wrappedQ <= 1'b0;
        fullQ    <= 1'b0;
      end else if (wrEn) begin
        wrPtrQ <= wrPtrQ + 1'b1;
        // Last word written, either wrap around or stop
        if (wrPtrQ == LastAddr) begin
          if (cfg_i.wrapMode) begin
            wrappedQ <= 1'b1;
          end else begin
            fullQ <= 1'b1;
          end
        end
      end
    end
  end

  assign ramWrEn_o   = wrEn;
  assign ramWrAddr_o = wrPtrQ;
  assign ramWrData_o = wrData;

  assign status_o.wrPtr   = wrPtrQ;
  assign status_o.wrapped = wrappedQ;
  assign status_o.full    = fullQ;

  // Stall during the held-beat cycle and while the RAM is full
  assign traceBp_o = holdQ.vld | fullQ;

endmodule

`default_nettype wire

// File: verif/traceFunnelTb.sv
// Trace funnel testbench
// APB and branch stimulus with value checks against the register and sink rules

`timescale 1ns/1ps
`default_nettype none

`include "traceFunnel_consts.svh"

module traceFunnelTb;

  // Twice roughly 80 APB accesses of up to 5 cycles and 60 beats of 2 cycles
  localparam int MaxCycles = 2 * (80 * 5 + 60 * 2);

  logic        clk = 1'b0;
  logic        reset_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [7:0]  paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;
  logic [3:0]  evenVld_i;
  logic        evenSrc_i;
  logic [31:0] evenData_i;
  logic [3:0]  oddVld_i;
  logic        oddSrc_i;
  logic [31:0] oddData_i;
  logic        traceBp_o;
  logic [7:0]  enabledSrcs_o;
  logic        funnelActive_o;

  integer      seed = 32'hab6dfe84;
  int          cycles = 0;
  int          testErrors = 0;
  int          totalErrors = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  logic [31:0] beats [$];

  traceFunnel UUT (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Checks and bookkeeping
  // --------------------------------------------------
  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      testErrors++;
    end
  endtask

  task automatic endTest(input string name);
    testsRun++;
    totalErrors += testErrors;
    if (testErrors == 0) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, testErrors);
      testsFailed++;
    end
    testErrors = 0;
  endtask

  // Expected physical enables from the fuse map and virtual disable rule
  function automatic logic [7:0] expectedSources(input logic active, input logic [31:0] fuse,
                                                 input logic [7:0] disMask);
    logic [7:0] en;
    logic [2:0] vid;
    en = '0;
    for (int p = 0; p < 8; p++) begin
      vid   = fuse[p*4 +: 3];
      en[p] = active & fuse[p*4 + 3] & ~disMask[vid];
    end
    return en;
  endfunction

  // --------------------------------------------------
  // APB and branch drivers
  // --------------------------------------------------
  task automatic apbAccess(input logic write, input logic [7:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk);
    penable_i = 1'b1;
    #1;
    while (!pready_o) begin
      @(negedge clk);
      #1;
    end
    rdata = prdata_o;
    checkValue("apb pslverr", 32'h0, 32'(pslverr_o));
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] ignored;
    apbAccess(1'b1, addr, data, ignored);
  endtask

  task automatic checkRead(input string name, input logic [7:0] addr,
                           input logic [31:0] expected);
    logic [31:0] data;
    apbAccess(1'b0, addr, 32'h0, data);
    checkValue(name, expected, data);
  endtask

  // One beat per call held for a single cycle
  task automatic driveBeat(input logic [3:0] ev, input logic [31:0] ed,
                           input logic [3:0] ov, input logic [31:0] od);
    @(negedge clk);
    evenVld_i  = ev;
    evenData_i = ed;
    oddVld_i   = ov;
    oddData_i  = od;
    @(negedge clk);
    evenVld_i = '0;
    oddVld_i  = '0;
  endtask

  task automatic sendRandomBeats(input int count);
    logic [31:0] data;
    logic [3:0]  vld;
    for (int k = 0; k < count; k++) begin
      data = $random(seed);
      vld  = 4'b0001 << (k % 4);
      beats.push_back(data);
      if (k % 2 == 0) begin
        driveBeat(vld, data, 4'b0, 32'h0);
      end else begin
        driveBeat(4'b0, 32'h0, vld, data);
      end
    end
  endtask

  task automatic checkRamContents(input string name, input int start, input int count,
                                  input int first);
    logic [31:0] data;
    apbWrite(`TF_REG_RP, 32'(start));
    for (int k = 0; k < count; k++) begin
      apbAccess(1'b0, `TF_REG_DATA, 32'h0, data);
      checkValue(name, beats[first + k], data);
    end
    checkRead({name, " read pointer"}, `TF_REG_RP, 32'((start + count) % 16));
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] fuseWord;
    logic [7:0]  disMask;
    logic [7:0]  expEn;
    logic [31:0] evenWord;
    logic [31:0] oddWord;
    reset_i    = 1'b1;
    psel_i     = 1'b0;
    penable_i  = 1'b0;
    pwrite_i   = 1'b0;
    paddr_i    = '0;
    pwdata_i   = '0;
    evenVld_i  = '0;
    evenSrc_i  = 1'b0;
    evenData_i = '0;
    oddVld_i   = '0;
    oddSrc_i   = 1'b1;
    oddData_i  = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    // Reset values and register readback
    checkValue("reset traceBp", 32'h0, 32'(traceBp_o));
    checkValue("reset enabledSrcs", 32'h0, 32'(enabledSrcs_o));
    checkValue("reset funnelActive", 32'h0, 32'(funnelActive_o));
    checkValue("reset pready", 32'h0, 32'(pready_o));
    checkRead("reset control", `TF_REG_CONTROL, 32'h0);
    checkRead("reset disable", `TF_REG_DISABLE, 32'h0);
    checkRead("reset fuse", `TF_REG_FUSE, 32'h0);
    checkRead("reset ramctrl", `TF_REG_RAMCTRL, 32'h0);
    checkRead("reset wp", `TF_REG_WP, 32'h0);
    checkRead("reset rp", `TF_REG_RP, 32'h0);
    checkRead("reset status", `TF_REG_STATUS, 32'h0);
    apbWrite(`TF_REG_CONTROL, 32'h1);
    apbWrite(`TF_REG_DISABLE, 32'h5A);
    apbWrite(`TF_REG_FUSE, 32'hFEDC_BA98);
    apbWrite(`TF_REG_RAMCTRL, 32'h3);
    checkRead("readback control", `TF_REG_CONTROL, 32'h1);
    checkRead("readback disable", `TF_REG_DISABLE, 32'h5A);
    checkRead("readback fuse", `TF_REG_FUSE, 32'hFEDC_BA98);
    checkRead("readback ramctrl", `TF_REG_RAMCTRL, 32'h3);
    checkValue("readback funnelActive", 32'h1, 32'(funnelActive_o));
    apbWrite(`TF_REG_CONTROL, 32'h0);
    apbWrite(`TF_REG_RAMCTRL, 32'h0);
    endTest("registers");

    // Permuted virtual IDs with cores 2 and 5 fused off
    for (int p = 0; p < 8; p++) begin
      fuseWord[p*4 +: 4] = {1'(p != 2 && p != 5), 3'(7 - p)};
    end
    disMask = 8'b0001_0010;
    apbWrite(`TF_REG_FUSE, fuseWord);
    apbWrite(`TF_REG_DISABLE, 32'(disMask));
    @(negedge clk);
    checkValue("inactive enabledSrcs", 32'h0, 32'(enabledSrcs_o));
    checkRead("inactive status", `TF_REG_STATUS, 32'h0);
    apbWrite(`TF_REG_CONTROL, 32'h1);
    #1;
    checkValue("enabledSrcs before update", 32'h0, 32'(enabledSrcs_o));
    @(negedge clk);
    expEn = expectedSources(1'b1, fuseWord, disMask);
    checkValue("active enabledSrcs", 32'(expEn), 32'(enabledSrcs_o));
    checkRead("active status", `TF_REG_STATUS, 32'($countones(expEn)));
    endTest("source map");

    // Single branch beats in arrival order
    apbWrite(`TF_REG_RAMCTRL, 32'h1);
    apbWrite(`TF_REG_WP, 32'h0);
    beats.delete();
    sendRandomBeats(10);
    checkRead("single wp", `TF_REG_WP, 32'd10);
    checkRamContents("single data", 0, 10, 0);
    endTest("single branch");

    // Even beat first and odd beat held for one cycle
    apbWrite(`TF_REG_WP, 32'h0);
    beats.delete();
    evenWord = $random(seed);
    oddWord  = $random(seed);
    beats.push_back(evenWord);
    beats.push_back(oddWord);
    driveBeat(4'b0010, evenWord, 4'b1000, oddWord);
    #1;
    checkValue("collision traceBp", 32'h1, 32'(traceBp_o));
    @(negedge clk);
    #1;
    checkValue("collision traceBp release", 32'h0, 32'(traceBp_o));
    checkRead("collision wp", `TF_REG_WP, 32'd2);
    checkRamContents("collision data", 0, 2, 0);
    endTest("collision");

    // Stop at full and then keep the latest beats in wrap mode
    apbWrite(`TF_REG_WP, 32'h0);
    beats.delete();
    sendRandomBeats(20);
    checkRead("full wp", `TF_REG_WP, 32'h4000_0000);
    checkValue("full traceBp", 32'h1, 32'(traceBp_o));
    apbWrite(`TF_REG_WP, 32'h0);
    #1;
    checkValue("cleared traceBp", 32'h0, 32'(traceBp_o));
    checkRead("cleared wp", `TF_REG_WP, 32'h0);
    apbWrite(`TF_REG_RAMCTRL, 32'h3);
    beats.delete();
    sendRandomBeats(21);
    checkRead("wrap wp", `TF_REG_WP, 32'h8000_0005);
    checkRamContents("wrap data", 5, 16, 5);
    endTest("full and wrap");

    // Beats dropped with the RAM off or the funnel inactive
    apbWrite(`TF_REG_RAMCTRL, 32'h1);
    apbWrite(`TF_REG_WP, 32'h0);
    beats.delete();
    sendRandomBeats(2);
    checkRead("enabled wp", `TF_REG_WP, 32'd2);
    apbWrite(`TF_REG_RAMCTRL, 32'h0);
    sendRandomBeats(3);
    checkRead("ram off wp", `TF_REG_WP, 32'd2);
    apbWrite(`TF_REG_RAMCTRL, 32'h1);
    apbWrite(`TF_REG_CONTROL, 32'h0);
    sendRandomBeats(3);
    checkRead("inactive wp", `TF_REG_WP, 32'd2);
    endTest("dropped beats");

    $display("Tests run %0d, failed %0d, check errors %0d, property errors %0d",
             testsRun, testsFailed, totalErrors, UUT.props.failCount);
    if (totalErrors == 0 && testsFailed == 0 && UUT.props.failCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/traceFunnel_props.sv
// Trace funnel properties
// APB wait states and back-pressure behavior, bound into the top level

`timescale 1ns/1ps
`default_nettype none

`include "traceFunnel_consts.svh"

module traceFunnelProps (
  input logic                          clk,
  input logic                          reset_i,
  input logic                          psel_i,
  input logic                          penable_i,
  input logic                          pwrite_i,
  input logic [`TF_APB_ADDR_WIDTH-1:0] paddr_i,
  input logic                          pready_i,
  input logic [`TF_BRANCH_CORES-1:0]   evenVld_i,
  input logic [`TF_BRANCH_CORES-1:0]   oddVld_i,
  input logic                          active_i,
  input logic                          ramEn_i,
  input logic                          traceBp_i
);

  int   failCount = 0;
  logic access;
  logic dataRead;

  assign access   = psel_i & penable_i;
  assign dataRead = ~pwrite_i & (paddr_i == `TF_REG_DATA);

  // --------------------------------------------------
  // APB
  // --------------------------------------------------
  readyOnlyInAccess: assert property (@(posedge clk) disable iff (reset_i)
    !access |-> !pready_i)
  else begin
    $error("pready high outside the access phase");
    failCount++;
  end

  // First access cycle is the one after setup
  dataReadOneWait: assert property (@(posedge clk) disable iff (reset_i)
    access && !$past(penable_i) && dataRead |-> !pready_i ##1 pready_i)
  else begin
    $error("RAM data read did not take exactly one wait state");
    failCount++;
  end

  otherAccessNoWait: assert property (@(posedge clk) disable iff (reset_i)
    access && !$past(penable_i) && !dataRead |-> pready_i)
  else begin
    $error("register access took a wait state");
    failCount++;
  end

  // --------------------------------------------------
  // Back-pressure
  // --------------------------------------------------
  bpLowAfterReset: assert property (@(posedge clk)
    $fell(reset_i) |-> !traceBp_i)
  else begin
    $error("back-pressure high in the first cycle after reset");
    failCount++;
  end

  bpOnCollision: assert property (@(posedge clk) disable iff (reset_i)
    (|evenVld_i) && (|oddVld_i) && active_i && ramEn_i && !traceBp_i |=> traceBp_i)
  else begin
    $error("back-pressure did not rise after both branches were valid");
    failCount++;
  end

endmodule

bind traceFunnel traceFunnelProps props (
  .clk       (clk),
  .reset_i   (reset_i),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pwrite_i  (pwrite_i),
  .paddr_i   (paddr_i),
  .pready_i  (pready_o),
  .evenVld_i (evenVld_i),
  .oddVld_i  (oddVld_i),
  .active_i  (cfg.active),
  .ramEn_i   (cfg.ramEn),
  .traceBp_i (traceBp_o)
);

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/traceFunnelPkg.sv
logic/traceRam.sv
logic/traceSink.sv
logic/sourceEnableMap.sv
logic/traceFunnelRegs.sv
logic/traceFunnel.sv
verif/traceFunnel_props.sv
verif/traceFunnelTb.sv
